//--- bench/exwb_tb.sv
// testbench for the execute/writeback cluster
// table and random operations checked against a reference model at retire
`timescale 1ns/10ps

module exwb_tb
    import exwb_pkg::*;
();

    localparam int TABLE_LEN      = 22;
    localparam int RAND_LEN       = 24;
    localparam int TOTAL_LEN      = TABLE_LEN + RAND_LEN;
    localparam int MUL_IDX        = 16;   // multiply that the next ALU op overtakes
    localparam int ALU_AFTER_MUL  = 17;
    localparam int TIMEOUT_CYCLES = TOTAL_LEN * (MUL_STEPS + 8) + 100;

    typedef struct packed {
        issue_t          ins;
        logic [XLEN-1:0] exp;
    } entry_t;

    logic   clk = 1'b0;
    logic   rst_i;
    logic   issue_valid_i;
    issue_t issue_i;
    logic   issue_ready_o;
    logic   retire_valid_o;
    wb_t    retire_o;

    entry_t          entries[$];
    int              pending[$];           // accepted, not yet retired
    int              retire_pos [TOTAL_LEN];
    logic [XLEN-1:0] model_regs [NUM_REGS];
    int              seed = 32'he5a8;
    int              retire_cnt = 0;
    int              check_cnt = 0;
    int              error_cnt = 0;
    int              cycle_cnt = 0;
    int              errs_before;

    exwb_top UUT (
        .clk            (clk),
        .rst_i          (rst_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .issue_ready_o  (issue_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    always #50 clk = ~clk;

    // wrap-around arithmetic, low word of the product
    function automatic logic [XLEN-1:0] model_result(op_e op, logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b);
        case (op)
            OP_ADD, OP_ADDI: return a + b;
            OP_SUB:          return a - b;
            OP_AND:          return a & b;
            OP_OR:           return a | b;
            OP_XOR:          return a ^ b;
            OP_MUL:          return a * b;
            default:         return '0;
        endcase
    endfunction

    task automatic add_entry(op_e op, int rd, int rs1, int rs2, logic [XLEN-1:0] imm,
                             logic [XLEN-1:0] exp);
        entry_t e;
        e.ins.op  = op;
        e.ins.rd  = REG_ADDR_W'(rd);
        e.ins.rs1 = REG_ADDR_W'(rs1);
        e.ins.rs2 = REG_ADDR_W'(rs2);
        e.ins.imm = imm;
        e.exp     = exp;
        entries.push_back(e);
        if (rd != 0) model_regs[rd] = exp;  // x0 keeps reading zero
    endtask

    task automatic build_table();
        add_entry(OP_ADDI,  1,  0,  0, 32'd5,          32'd5);
        add_entry(OP_ADDI,  2,  0,  0, 32'd12,         32'd12);
        add_entry(OP_ADD,   3,  1,  2, 32'd0,          32'd17);
        add_entry(OP_SUB,   4,  1,  2, 32'd0,          32'hFFFF_FFF9);
        add_entry(OP_ADDI,  6,  0,  0, 32'h0000_F0F0,  32'h0000_F0F0);
        add_entry(OP_ADDI,  7,  0,  0, 32'h0000_FF00,  32'h0000_FF00);
        add_entry(OP_AND,   8,  6,  7, 32'd0,          32'h0000_F000);
        add_entry(OP_OR,    9,  6,  7, 32'd0,          32'h0000_FFF0);
        add_entry(OP_XOR,  10,  6,  7, 32'd0,          32'h0000_0FF0);
        add_entry(OP_ADDI, 11,  4,  0, 32'hFFFF_FFFF,  32'hFFFF_FFF8);
        // dependent chain, including a write to x0
        add_entry(OP_ADD,  12,  3,  3, 32'd0,          32'd34);
        add_entry(OP_SUB,  12, 12,  1, 32'd0,          32'd29);
        add_entry(OP_ADDI,  0, 12,  0, 32'd100,        32'd129);
        add_entry(OP_ADD,  13,  0, 12, 32'd0,          32'd29);
        // multiplies
        add_entry(OP_ADDI, 14,  0,  0, 32'd1234,       32'd1234);
        add_entry(OP_ADDI, 15,  0,  0, 32'hFFFF_FFFD,  32'hFFFF_FFFD);
        add_entry(OP_MUL,  16, 14, 15, 32'd0,          32'hFFFF_F18A);
        add_entry(OP_ADDI, 17,  1,  0, 32'd7,          32'd12);
        add_entry(OP_MUL,  18, 16,  2, 32'd0,          32'hFFFF_5278);
        add_entry(OP_ADD,  19, 18, 16, 32'd0,          32'hFFFF_4402);
        add_entry(OP_MUL,  20,  7,  6, 32'd0,          32'hEFFF_1000);
        add_entry(OP_MUL,  21, 20, 20, 32'd0,          32'hE100_0000);
    endtask

    // sources from table registers, targets x22..x31
    task automatic add_random_entry();
        op_e             op;
        int              rd;
        int              rs1;
        int              rs2;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] b;
        op  = op_e'(3'($unsigned($random(seed)) % 7));
        rd  = 22 + int'($unsigned($random(seed)) % 10);
        rs1 = int'($unsigned($random(seed)) % 22);
        rs2 = int'($unsigned($random(seed)) % 22);
        imm = $random(seed);
        b   = (op == OP_ADDI) ? imm : model_regs[rs2];
        add_entry(op, rd, rs1, rs2, imm, model_result(op, model_regs[rs1], b));
    endtask

    // called on a rising edge, holds each entry until accepted
    task automatic apply_entries(int first, int last);
        for (int i = first; i <= last; i++) begin
            issue_valid_i <= 1'b1;
            issue_i       <= entries[i].ins;
            @(posedge clk);
            while (!issue_ready_o) @(posedge clk);
            pending.push_back(i);
        end
        issue_valid_i <= 1'b0;
    endtask

    task automatic wait_drain();
        while (pending.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);  // a late extra retirement still gets counted
    endtask

    task automatic report_test(string name, int errs);
        $display("test %s finished with %0d errors", name, error_cnt - errs);
    endtask

    // oldest waiting entry with the same rd, unique thanks to the WAW stall
    task automatic check_retire(wb_t r);
        int k;
        int idx;
        k = -1;
        for (int j = 0; j < pending.size(); j++) begin
            if (k < 0 && entries[pending[j]].ins.rd == r.rd) k = j;
        end
        retire_cnt++;  // every retirement, matched or not
        if (k < 0) begin
            $display("error at %0t ns: retirement for x%0d without a waiting operation",
                     $time, r.rd);
            error_cnt++;
        end else begin
            idx = pending[k];
            pending.delete(k);
            retire_pos[idx] = retire_cnt;
            check_cnt++;
            assert (r.data == entries[idx].exp) else begin
                $display({"CHECK FAILED at %0t ns: retire_o.data (entry %0d, x%0d) ",
                          "expected %h got %h"},
                         $time, idx, r.rd, entries[idx].exp, r.data);
                error_cnt++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_i && retire_valid_o) check_retire(retire_o);
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d operations not retired",
                     cycle_cnt, pending.size());
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;

        errs_before = error_cnt;
        repeat (4) begin
            @(posedge clk);
            check_cnt += 2;
            assert (retire_valid_o == 1'b0) else begin
                $display("CHECK FAILED at %0t ns: retire_valid_o expected 0 got %b",
                         $time, retire_valid_o);
                error_cnt++;
            end
            assert (issue_ready_o == 1'b1) else begin
                $display("CHECK FAILED at %0t ns: issue_ready_o expected 1 got %b",
                         $time, issue_ready_o);
                error_cnt++;
            end
        end
        report_test("reset_idle", errs_before);

        errs_before = error_cnt;
        build_table();
        apply_entries(0, TABLE_LEN - 1);
        wait_drain();
        report_test("table_ops", errs_before);

        errs_before = error_cnt;
        check_cnt++;
        assert (retire_pos[ALU_AFTER_MUL] < retire_pos[MUL_IDX]) else begin
            $display("error: ALU operation issued after the multiply did not retire first");
            error_cnt++;
        end
        report_test("mul_overtake", errs_before);

        errs_before = error_cnt;
        repeat (RAND_LEN) add_random_entry();
        apply_entries(TABLE_LEN, TOTAL_LEN - 1);
        wait_drain();
        check_cnt++;
        assert (retire_cnt == TOTAL_LEN) else begin
            $display("error: %0d retirements for %0d issued operations",
                     retire_cnt, TOTAL_LEN);
            error_cnt++;
        end
        report_test("random_stream", errs_before);

        $display("summary: %0d checks, %0d errors", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- exwb.f
src/exwb_pkg.sv
src/gpr_file.sv
src/alu_unit.sv
src/muldiv_unit.sv
src/hazard_unit.sv
src/wb_arbiter.sv
src/exwb_top.sv
bench/exwb_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the exwb testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f exwb.f --top-module exwb_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vexwb_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- src/alu_unit.sv
// single cycle ALU with registered result
// holds writeback credits for its arbiter queue
`timescale 1ns/10ps

module alu_unit
    import exwb_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      fire_i,
    input  exec_req_t req_i,
    output logic      credit_ok_o,
    input  logic      credit_ret_i,
    output logic      res_valid_o,
    output wb_t       res_o
);

    logic [CREDIT_W-1:0] credit_q;
    logic                res_valid_q;
    wb_t                 res_q;
    logic [XLEN-1:0]     alu_out;

    always_comb begin
        case (req_i.op)
            OP_ADD, OP_ADDI: alu_out = req_i.a + req_i.b;
            OP_SUB:          alu_out = req_i.a - req_i.b;
            OP_AND:          alu_out = req_i.a & req_i.b;
            OP_OR:           alu_out = req_i.a | req_i.b;
            OP_XOR:          alu_out = req_i.a ^ req_i.b;
            default:         alu_out = '0;  // mul never routed here
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            res_valid_q <= 1'b0;
            credit_q    <= CREDIT_W'(WB_CREDITS);
        end else begin
            res_valid_q <= fire_i;
            // slot reserved at fire, given back when the arbiter retires it
            credit_q    <= credit_q - CREDIT_W'(fire_i) + CREDIT_W'(credit_ret_i);
        end
    end

    always_ff @(posedge clk) begin
        if (fire_i) begin
            res_q.rd   <= req_i.rd;
            res_q.data <= alu_out;
        end
    end

    assign credit_ok_o = (credit_q != '0);
    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

    // hazard unit must respect the credit count
    a_fire_has_credit: assert property (@(posedge clk) disable iff (rst_i)
        fire_i |-> (credit_q != '0));

endmodule

//--- src/exwb_pkg.sv
// execute/writeback cluster shared definitions
// widths, credit and multiply constants, operation and payload types
package exwb_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int WB_CREDITS = 2;   // queue slots per unit in writeback
    localparam int CREDIT_W   = 2;
    localparam int MUL_STEPS  = 32;  // one partial product per step

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_MUL
    } op_e;

    // decoded operation at the issue port
    typedef struct packed {
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
    } issue_t;

    // operands already resolved, b is imm for addi
    typedef struct packed {
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
    } exec_req_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

//--- src/exwb_top.sv
// execute and writeback cluster top
// register file, hazard scoreboard, ALU, multiplier and writeback arbiter
`timescale 1ns/10ps

module exwb_top
    import exwb_pkg::*;
(
    input  logic   clk,
    input  logic   rst_i,
    input  logic   issue_valid_i,
    input  issue_t issue_i,
    output logic   issue_ready_o,
    output logic   retire_valid_o,
    output wb_t    retire_o
);

    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    exec_req_t       exec_req;
    logic            alu_fire;
    logic            mul_fire;
    logic            alu_ok;
    logic            mul_ok;
    logic            alu_ret;
    logic            mul_ret;
    logic            alu_valid;
    logic            mul_valid;
    wb_t             alu_res;
    wb_t             mul_res;

    // operands straight from the register file, imm replaces rs2 for addi
    assign exec_req = '{op: issue_i.op,
                        rd: issue_i.rd,
                        a:  rdata1,
                        b:  (issue_i.op == OP_ADDI) ? issue_i.imm : rdata2};

    gpr_file u_gpr_file (
        .clk      (clk),
        .rst_i    (rst_i),
        .raddr1_i (issue_i.rs1),
        .raddr2_i (issue_i.rs2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (retire_valid_o),
        .wr_i     (retire_o)
    );

    hazard_unit u_hazard_unit (
        .clk            (clk),
        .rst_i          (rst_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .alu_ok_i       (alu_ok),
        .mul_ok_i       (mul_ok),
        .retire_valid_i (retire_valid_o),
        .retire_rd_i    (retire_o.rd),
        .issue_ready_o  (issue_ready_o),
        .alu_fire_o     (alu_fire),
        .mul_fire_o     (mul_fire)
    );

    alu_unit u_alu_unit (
        .clk          (clk),
        .rst_i        (rst_i),
        .fire_i       (alu_fire),
        .req_i        (exec_req),
        .credit_ok_o  (alu_ok),
        .credit_ret_i (alu_ret),
        .res_valid_o  (alu_valid),
        .res_o        (alu_res)
    );

    muldiv_unit u_muldiv_unit (
        .clk          (clk),
        .rst_i        (rst_i),
        .fire_i       (mul_fire),
        .req_i        (exec_req),
        .credit_ok_o  (mul_ok),
        .credit_ret_i (mul_ret),
        .res_valid_o  (mul_valid),
        .res_o        (mul_res)
    );

    wb_arbiter u_wb_arbiter (
        .clk            (clk),
        .rst_i          (rst_i),
        .alu_valid_i    (alu_valid),
        .alu_res_i      (alu_res),
        .mul_valid_i    (mul_valid),
        .mul_res_i      (mul_res),
        .alu_credit_o   (alu_ret),
        .mul_credit_o   (mul_ret),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

//--- src/gpr_file.sv
// general purpose register file
// two async read ports, one write port fed by writeback
`timescale 1ns/10ps

module gpr_file
    import exwb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o,
    input  logic                  we_i,
    input  wb_t                   wr_i
);

    logic [XLEN-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (wr_i.rd != '0)) begin  // x0 writes dropped
            regs_q[wr_i.rd] <= wr_i.data;
        end
    end

    // x0 hardwired to zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

//--- src/hazard_unit.sv
// scoreboard with one busy bit per register
// stalls issue on RAW/WAW conflicts and steers accepted ops to a unit
`timescale 1ns/10ps

module hazard_unit
    import exwb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  issue_valid_i,
    input  issue_t                issue_i,
    input  logic                  alu_ok_i,
    input  logic                  mul_ok_i,
    input  logic                  retire_valid_i,
    input  logic [REG_ADDR_W-1:0] retire_rd_i,
    output logic                  issue_ready_o,
    output logic                  alu_fire_o,
    output logic                  mul_fire_o
);

    logic [NUM_REGS-1:0] busy_q;   // bit 0 never set
    logic                is_mul;
    logic                rs2_used;
    logic                conflict;
    logic                accept;

    assign is_mul   = (issue_i.op == OP_MUL);
    assign rs2_used = (issue_i.op != OP_ADDI);
    assign conflict = busy_q[issue_i.rs1] | busy_q[issue_i.rd]
                    | (rs2_used & busy_q[issue_i.rs2]);

    assign issue_ready_o = !conflict && (is_mul ? mul_ok_i : alu_ok_i);
    assign accept        = issue_valid_i && issue_ready_o;
    assign alu_fire_o    = accept && !is_mul;
    assign mul_fire_o    = accept && is_mul;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= '0;
        end else begin
            if (retire_valid_i) busy_q[retire_rd_i] <= 1'b0;
            // accepted rd is free, so never the same bit as the retire
            if (accept && (issue_i.rd != '0)) busy_q[issue_i.rd] <= 1'b1;
        end
    end

    a_retire_busy: assert property (@(posedge clk) disable iff (rst_i)
        (retire_valid_i && (retire_rd_i != '0)) |-> busy_q[retire_rd_i]);

endmodule

//--- src/muldiv_unit.sv
// iterative shift-add multiplier, low word of the product only
// busy for MUL_STEPS cycles, then presents the result for one cycle
`timescale 1ns/10ps

module muldiv_unit
    import exwb_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      fire_i,
    input  exec_req_t req_i,
    output logic      credit_ok_o,
    input  logic      credit_ret_i,
    output logic      res_valid_o,
    output wb_t       res_o
);

    localparam int CNT_W = $clog2(MUL_STEPS + 1);

    logic [CNT_W-1:0]      step_q;    // steps left, zero when idle
    logic [CREDIT_W-1:0]   credit_q;
    logic                  res_valid_q;
    logic [XLEN-1:0]       acc_q;
    logic [XLEN-1:0]       mcand_q;
    logic [XLEN-1:0]       mplier_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [XLEN-1:0]       acc_next;
    logic                  busy;

    assign busy     = (step_q != '0);
    assign acc_next = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            step_q      <= '0;
            res_valid_q <= 1'b0;
            credit_q    <= CREDIT_W'(WB_CREDITS);
        end else begin
            res_valid_q <= (step_q == CNT_W'(1));  // last step this edge
            if (fire_i) begin
                step_q <= CNT_W'(MUL_STEPS);
            end else if (busy) begin
                step_q <= step_q - 1'b1;
            end
            credit_q <= credit_q - CREDIT_W'(fire_i) + CREDIT_W'(credit_ret_i);
        end
    end

    // datapath, meaningful only while busy or presenting
    always_ff @(posedge clk) begin
        if (fire_i) begin
            acc_q    <= '0;
            mcand_q  <= req_i.a;
            mplier_q <= req_i.b;
            rd_q     <= req_i.rd;
        end else if (busy) begin
            acc_q    <= acc_next;
            mcand_q  <= mcand_q << 1;   // upper bits fall off, low word only
            mplier_q <= mplier_q >> 1;
        end
    end

    assign credit_ok_o = !busy && (credit_q != '0);
    assign res_valid_o = res_valid_q;
    assign res_o       = '{rd: rd_q, data: acc_q};

    // a second multiply would corrupt the one in progress
    a_no_fire_busy: assert property (@(posedge clk) disable iff (rst_i)
        fire_i |-> !busy);

endmodule

//--- src/wb_arbiter.sv
// writeback arbiter with one small result queue per unit
// multiplier queue wins, one retire per cycle, credit returned on pop
`timescale 1ns/10ps

module wb_arbiter
    import exwb_pkg::*;
(
    input  logic clk,
    input  logic rst_i,
    input  logic alu_valid_i,
    input  wb_t  alu_res_i,
    input  logic mul_valid_i,
    input  wb_t  mul_res_i,
    output logic alu_credit_o,
    output logic mul_credit_o,
    output logic retire_valid_o,
    output wb_t  retire_o
);

    localparam int PTR_W = $clog2(WB_CREDITS);

    // queue 0 holds alu results, queue 1 multiplier results
    wb_t                 q_mem  [2][WB_CREDITS];
    logic [PTR_W-1:0]    wr_ptr [2];
    logic [PTR_W-1:0]    rd_ptr [2];
    logic [CREDIT_W-1:0] q_cnt  [2];
    logic                push   [2];
    logic                pop    [2];
    wb_t                 push_data [2];
    logic                retire_valid_q;
    wb_t                 retire_q;

    assign push[0]      = alu_valid_i;
    assign push[1]      = mul_valid_i;
    assign push_data[0] = alu_res_i;
    assign push_data[1] = mul_res_i;

    assign pop[1] = (q_cnt[1] != '0);
    assign pop[0] = (q_cnt[0] != '0) && !pop[1];  // fixed priority

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 2; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                q_cnt[i]  <= '0;
            end
            retire_valid_q <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (push[i]) begin
                    wr_ptr[i] <= (wr_ptr[i] == PTR_W'(WB_CREDITS - 1)) ? '0 : wr_ptr[i] + 1'b1;
                end
                if (pop[i]) begin
                    rd_ptr[i] <= (rd_ptr[i] == PTR_W'(WB_CREDITS - 1)) ? '0 : rd_ptr[i] + 1'b1;
                end
                q_cnt[i] <= q_cnt[i] + CREDIT_W'(push[i]) - CREDIT_W'(pop[i]);
            end
            retire_valid_q <= pop[0] | pop[1];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (push[i]) q_mem[i][wr_ptr[i]] <= push_data[i];
        end
        retire_q <= pop[1] ? q_mem[1][rd_ptr[1]] : q_mem[0][rd_ptr[0]];
    end

    assign alu_credit_o   = pop[0];
    assign mul_credit_o   = pop[1];
    assign retire_valid_o = retire_valid_q;
    assign retire_o       = retire_q;

    // units must never send beyond their credits
    a_alu_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
        alu_valid_i |-> (q_cnt[0] != CREDIT_W'(WB_CREDITS)));
    a_mul_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
        mul_valid_i |-> (q_cnt[1] != CREDIT_W'(WB_CREDITS)));

endmodule
